//--- build.f
hw/cachePkg.sv
hw/cacheController.sv
hw/cacheTagStore.sv
hw/cacheDataStore.sv
hw/dataCache.sv
tests/memoryModel.sv
tests/dataCacheTb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module dataCacheTb -o simDataCache; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simDataCache)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF -e '*** TEST PASSED ***' <<< "$output"; then
  exit 0
fi
exit 1

//--- tests/dataCacheTb.sv
module dataCacheTb;

  localparam int numSets = 4;
  localparam int driveDelay = 5;
  localparam int timeoutCycles = 1000;
  localparam logic [31:0] randomSeed = 32'h7a620f3c;

  logic             clk;
  logic             reset;
  cachePkg::cpuReqT cpuReq;
  logic             flush;
  logic             busReady;
  cachePkg::wordT   busRdata;
  logic             stall;
  cachePkg::wordT   rdata;
  cachePkg::busReqT busReq;
  int               writeBeats;

  // Latest value of every memory word
  cachePkg::wordT       model [256];
  integer               seed;
  int                   beatTotal;
  cachePkg::wordOffsetT expectedOffset;
  logic [27:0]          burstBlock;
  logic                 burstWrite;

  dataCache #(.numSets(numSets)) dut (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .flush(flush),
    .busReady(busReady),
    .busRdata(busRdata),
    .stall(stall),
    .rdata(rdata),
    .busReq(busReq)
  );

  memoryModel #(.delaySeed(randomSeed)) busMemory (
    .clk(clk),
    .reset(reset),
    .busReq(busReq),
    .busReady(busReady),
    .busRdata(busRdata),
    .writeBeats(writeBeats)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
    stopRun($sformatf("Error at time %0t: %s = %h, expected %h", $time, name, actual,
                      expected));
  endtask

  function automatic cachePkg::wordT mergeBytes(cachePkg::wordT oldWord,
                                                cachePkg::wordT newWord,
                                                cachePkg::byteMaskT mask);
    cachePkg::wordT result;
    result = oldWord;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        result[8*b +: 8] = newWord[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Returns at the falling edge where stall is low
  task automatic waitForStallLow(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (stall) begin
      cycles++;
      if (cycles > timeoutCycles) begin
        stopRun("Timeout: stall stayed high and the cache never became ready");
      end
      @(negedge clk);
    end
  endtask

  task automatic doRequest(input logic isWrite, input cachePkg::addrT addr,
                           input cachePkg::wordT wdata, input cachePkg::byteMaskT mask,
                           output int waitCycles);
    int wordIndex;
    wordIndex = int'(addr[9:2]);
    cpuReq.read = !isWrite;
    cpuReq.write = isWrite;
    cpuReq.addr = addr;
    cpuReq.wdata = wdata;
    cpuReq.byteMask = mask;
    waitForStallLow(waitCycles);
    if (isWrite) begin
      model[wordIndex] = mergeBytes(model[wordIndex], wdata, mask);
    end else begin
      assert (rdata === model[wordIndex]) else reportMismatch("rdata", rdata, model[wordIndex]);
    end
    assert (expectedOffset == 2'd0) else stopRun("A bus burst was left unfinished");
    @(posedge clk);
    #driveDelay;
    cpuReq.read = 1'b0;
    cpuReq.write = 1'b0;
  endtask

  task automatic runFlush();
    int cycles;
    flush = 1'b1;
    @(posedge clk);
    #driveDelay;
    flush = 1'b0;
    waitForStallLow(cycles);
    assert (cycles > 0) else stopRun("stall did not rise in the cycle after the flush strobe");
    @(posedge clk);
    #driveDelay;
  endtask

  task automatic flushAndCheck();
    int beatsBefore;
    int writesBefore;
    runFlush();
    assert (expectedOffset == 2'd0) else stopRun("A bus burst was left unfinished by flush");
    for (int i = 0; i < 256; i++) begin
      assert (busMemory.words[i] === model[i])
        else reportMismatch($sformatf("busMemory.words[%0d]", i), busMemory.words[i], model[i]);
    end
    // Nothing is dirty any more
    beatsBefore = beatTotal;
    writesBefore = writeBeats;
    runFlush();
    assert (beatTotal == beatsBefore && writeBeats == writesBefore)
      else stopRun("A second flush without stores in between used the bus");
  endtask

  // Burst shape and write-back data
  always @(negedge clk) begin
    if (!reset && busReq.request && busReady) begin
      beatTotal++;
      assert (busReq.addr[3:2] == expectedOffset)
        else reportMismatch("busReq.addr[3:2]", 32'(busReq.addr[3:2]), 32'(expectedOffset));
      if (expectedOffset == 2'd0) begin
        burstBlock = busReq.addr[31:4];
        burstWrite = busReq.write;
      end
      assert (busReq.addr[31:4] == burstBlock)
        else reportMismatch("busReq.addr", busReq.addr, {burstBlock, 4'h0});
      assert (busReq.write == burstWrite) else stopRun("A bus burst mixed reads and writes");
      if (busReq.write) begin
        assert (busReq.wdata === model[busReq.addr[9:2]])
          else reportMismatch("busReq.wdata", busReq.wdata, model[busReq.addr[9:2]]);
      end
      expectedOffset = expectedOffset + 2'd1;
    end
  end

  initial begin
    logic [31:0]        r;
    int                 choice;
    logic               isWrite;
    cachePkg::addrT     addr;
    cachePkg::wordT     wdata;
    cachePkg::byteMaskT mask;
    int                 waitCycles;
    seed = randomSeed;
    reset = 1'b1;
    flush = 1'b0;
    cpuReq = '0;
    beatTotal = 0;
    expectedOffset = 2'd0;
    burstBlock = '0;
    burstWrite = 1'b0;
    repeat (2) @(posedge clk);
    #driveDelay;
    reset = 1'b0;
    for (int i = 0; i < 256; i++) begin
      model[i] = busMemory.words[i];
    end

    for (int op = 0; op < 400; op++) begin
      r = $random(seed);
      choice = int'(r % 32'd100);
      if (choice < 3) begin
        flushAndCheck();
      end else begin
        isWrite = choice < 50;
        r = $random(seed);
        // 32 blocks, eight per set
        addr = {23'd0, r[4:0], r[6:5], 2'b00};
        mask = r[10:7];
        wdata = $random(seed);
        doRequest(isWrite, addr, wdata, mask, waitCycles);
        if (r[11] && r[12]) begin
          doRequest(isWrite, addr, wdata, mask, waitCycles);
          assert (waitCycles == 0) else stopRun("A repeated request missed in the cache");
        end
        if (isWrite && r[13]) begin
          doRequest(1'b0, addr, '0, '0, waitCycles);
        end
      end
    end
    flushAndCheck();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- tests/memoryModel.sv
module memoryModel #(
  parameter logic [31:0] delaySeed = 32'h1
) (
  input  logic             clk,
  input  logic             reset,
  input  cachePkg::busReqT busReq,
  output logic             busReady,
  output cachePkg::wordT   busRdata,
  output int               writeBeats
);

  cachePkg::wordT words [256];
  integer seed;
  int delay;
  logic beatSeen;

  initial begin
    logic [7:0] a;
    seed = delaySeed;
    busReady = 1'b0;
    writeBeats = 0;
    beatSeen = 1'b0;
    delay = 0;
    // Pattern over all eight word address bits
    for (int i = 0; i < 256; i++) begin
      a = 8'(i);
      words[i] = {~a, a ^ 8'h5a, 8'hc3, a};
    end
  end

  assign busRdata = words[busReq.addr[9:2]];

  // A beat seen here completes on the next rising edge
  always @(negedge clk) begin
    if (!reset && busReq.request && busReady) begin
      beatSeen = 1'b1;
      if (busReq.write) begin
        words[busReq.addr[9:2]] = busReq.wdata;
        writeBeats++;
      end
    end
  end

  // New random wait of 0 to 3 cycles for every beat
  always @(posedge clk) begin
    #1;
    if (reset) begin
      busReady = 1'b0;
      beatSeen = 1'b0;
      delay = 0;
    end else begin
      if (beatSeen) begin
        busReady = 1'b0;
        beatSeen = 1'b0;
        delay = $unsigned($random(seed)) % 4;
      end
      if (busReq.request && !busReady) begin
        if (delay == 0) begin
          busReady = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

//--- hw/dataCache.sv
module dataCache #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets),
  localparam int tagBits = 32 - cachePkg::blockOffsetBits - indexBits
) (
  input  logic              clk,
  input  logic              reset,
  input  cachePkg::cpuReqT  cpuReq,
  input  logic              flush,
  input  logic              busReady,
  input  cachePkg::wordT    busRdata,
  output logic              stall,
  output cachePkg::wordT    rdata,
  output cachePkg::busReqT  busReq
);

  logic                 hit;
  logic                 hitWay;
  logic                 victimWay;
  logic                 victimDirty;
  logic [tagBits-1:0]   victimTag;
  logic [tagBits-1:0]   reqTag;
  logic [indexBits-1:0] index;
  logic                 way;
  cachePkg::wordOffsetT wordOffset;
  logic                 dataWrite;
  cachePkg::byteMaskT   dataMask;
  logic                 useBusData;
  logic                 tagWrite;
  logic                 setDirty;
  logic                 cleanLine;
  logic                 touchLru;
  cachePkg::wordT       storeWdata;
  cachePkg::busReqT     ctrlBusReq;

  assign reqTag = cpuReq.addr[31 -: tagBits];

  // Refill beats write bus data, store hits write processor data
  assign storeWdata = useBusData ? busRdata : cpuReq.wdata;

  // Write-back data comes straight from the data store
  always_comb begin
    busReq = ctrlBusReq;
    busReq.wdata = rdata;
  end

  cacheController #(.numSets(numSets)) controller (
    .clk(clk),
    .reset(reset),
    .cpuReq(cpuReq),
    .flush(flush),
    .hit(hit),
    .hitWay(hitWay),
    .victimWay(victimWay),
    .victimDirty(victimDirty),
    .victimTag(victimTag),
    .busReady(busReady),
    .stall(stall),
    .busReq(ctrlBusReq),
    .index(index),
    .way(way),
    .wordOffset(wordOffset),
    .dataWrite(dataWrite),
    .dataMask(dataMask),
    .useBusData(useBusData),
    .tagWrite(tagWrite),
    .setDirty(setDirty),
    .cleanLine(cleanLine),
    .touchLru(touchLru)
  );

  cacheTagStore #(.numSets(numSets)) tagStore (
    .clk(clk),
    .reset(reset),
    .index(index),
    .reqTag(reqTag),
    .tagWrite(tagWrite),
    .setDirty(setDirty),
    .cleanLine(cleanLine),
    .touchLru(touchLru),
    .way(way),
    .hit(hit),
    .hitWay(hitWay),
    .victimWay(victimWay),
    .victimDirty(victimDirty),
    .victimTag(victimTag)
  );

  cacheDataStore #(.numSets(numSets)) dataStore (
    .clk(clk),
    .index(index),
    .way(way),
    .wordOffset(wordOffset),
    .write(dataWrite),
    .mask(dataMask),
    .wdata(storeWdata),
    .rdata(rdata)
  );

endmodule

//--- hw/cacheDataStore.sv
module cacheDataStore #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets)
) (
  input  logic                 clk,
  input  logic [indexBits-1:0] index,
  input  logic                 way,
  input  cachePkg::wordOffsetT wordOffset,
  input  logic                 write,
  input  cachePkg::byteMaskT   mask,
  input  cachePkg::wordT       wdata,
  output cachePkg::wordT       rdata
);

  // Set, way, word within the block
  cachePkg::wordT lines [numSets][2][cachePkg::wordsPerBlock];

  always_ff @(posedge clk) begin
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          lines[index][way][wordOffset][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // Asynchronous read serves hits and write-back beats alike
  assign rdata = lines[index][way][wordOffset];

endmodule

//--- hw/cacheTagStore.sv
module cacheTagStore #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets),
  localparam int tagBits = 32 - cachePkg::blockOffsetBits - indexBits
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [indexBits-1:0] index,
  input  logic [tagBits-1:0]   reqTag,
  input  logic                 tagWrite,
  input  logic                 setDirty,
  input  logic                 cleanLine,
  input  logic                 touchLru,
  input  logic                 way,
  output logic                 hit,
  output logic                 hitWay,
  output logic                 victimWay,
  output logic                 victimDirty,
  output logic [tagBits-1:0]   victimTag
);

  logic [tagBits-1:0]      tags [numSets][2];
  logic [numSets-1:0][1:0] valid;
  logic [numSets-1:0][1:0] dirty;
  // Least recently used way of each set
  logic [numSets-1:0]      lru;
  logic [1:0]              wayHit;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = valid[index][w] && (tags[index][w] == reqTag);
    end
  end

  assign hit = |wayHit;
  assign hitWay = wayHit[1];

  // Fill an empty way before evicting anything
  assign victimWay = !valid[index][0] ? 1'b0 :
                     !valid[index][1] ? 1'b1 : lru[index];

  // Line state at the way the controller selects
  assign victimDirty = dirty[index][way];
  assign victimTag = tags[index][way];

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
      lru <= '0;
    end else begin
      if (tagWrite) begin
        valid[index][way] <= 1'b1;
        dirty[index][way] <= 1'b0;
      end
      if (setDirty) begin
        dirty[index][way] <= 1'b1;
      end
      if (cleanLine) begin
        dirty[index][way] <= 1'b0;
      end
      if (touchLru) begin
        lru[index] <= ~way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tagWrite) begin
      tags[index][way] <= reqTag;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(wayHit[0] && wayHit[1]));

endmodule

//--- hw/cacheController.sv
module cacheController #(
  parameter int numSets = 16,
  localparam int indexBits = $clog2(numSets),
  localparam int tagBits = 32 - cachePkg::blockOffsetBits - indexBits
) (
  input  logic                   clk,
  input  logic                   reset,
  input  cachePkg::cpuReqT       cpuReq,
  input  logic                   flush,
  input  logic                   hit,
  input  logic                   hitWay,
  input  logic                   victimWay,
  input  logic                   victimDirty,
  input  logic [tagBits-1:0]     victimTag,
  input  logic                   busReady,
  output logic                   stall,
  output cachePkg::busReqT       busReq,
  output logic [indexBits-1:0]   index,
  output logic                   way,
  output cachePkg::wordOffsetT   wordOffset,
  output logic                   dataWrite,
  output cachePkg::byteMaskT     dataMask,
  output logic                   useBusData,
  output logic                   tagWrite,
  output logic                   setDirty,
  output logic                   cleanLine,
  output logic                   touchLru
);

  localparam cachePkg::wordOffsetT lastBeat =
    cachePkg::wordOffsetT'(cachePkg::wordsPerBlock - 1);

  typedef enum logic [1:0] {
    readyState,
    writebackState,
    memReadState,
    flushState
  } stateT;

  stateT state, nextState;

  cachePkg::wordOffsetT beatCount;
  logic                 flushing;
  // Flush position, set index above the way bit
  logic [indexBits:0]   flushCount;
  logic                 missWay;
  logic                 active;
  logic                 miss;
  logic                 storeHit;
  logic                 beat;
  logic                 burstDone;
  logic [tagBits-1:0]   reqTag;
  logic [tagBits-1:0]   busTag;

  assign active = cpuReq.read | cpuReq.write;
  assign reqTag = cpuReq.addr[31 -: tagBits];
  assign miss = (state == readyState) & active & ~hit;
  assign storeHit = (state == readyState) & active & hit & cpuReq.write;
  assign beat = busReq.request & busReady;
  assign burstDone = beat & (beatCount == lastBeat);

  always_comb begin
    nextState = state;
    case (state)
      readyState: begin
        if (flush) begin
          nextState = flushState;
        end else if (miss) begin
          nextState = victimDirty ? writebackState : memReadState;
        end
      end
      writebackState: begin
        // A flush write-back returns to the walk
        if (burstDone) begin
          nextState = flushing ? flushState : memReadState;
        end
      end
      memReadState: begin
        if (burstDone) begin
          nextState = readyState;
        end
      end
      flushState: begin
        if (victimDirty) begin
          nextState = writebackState;
        end else if (&flushCount) begin
          nextState = readyState;
        end
      end
      default: nextState = readyState;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= readyState;
      beatCount <= '0;
      flushing <= 1'b0;
      flushCount <= '0;
      missWay <= 1'b0;
    end else begin
      state <= nextState;
      // Wraps to zero after the fourth beat
      if (beat) begin
        beatCount <= beatCount + 1'b1;
      end
      if (state == readyState && flush) begin
        flushing <= 1'b1;
      end else if (state == flushState && nextState == readyState) begin
        flushing <= 1'b0;
      end
      // Step only past clean lines, ends back at zero
      if (state == flushState && !victimDirty) begin
        flushCount <= flushCount + 1'b1;
      end
      if (miss) begin
        missWay <= victimWay;
      end
    end
  end

  assign index = flushing ? flushCount[indexBits:1]
                          : cpuReq.addr[cachePkg::blockOffsetBits +: indexBits];

  always_comb begin
    if (flushing) begin
      way = flushCount[0];
    end else if (state == readyState) begin
      way = hit ? hitWay : victimWay;
    end else begin
      way = missWay;
    end
  end

  assign stall = (state != readyState) | (active & ~hit);

  // Write-backs go to the victim's block, refills to the requested one
  assign busTag = (state == writebackState) ? victimTag : reqTag;

  always_comb begin
    busReq = '0;
    busReq.request = (state == writebackState) | (state == memReadState);
    busReq.write = (state == writebackState);
    busReq.addr = {busTag, index, beatCount, 2'b00};
  end

  assign wordOffset = (state == readyState) ? cpuReq.addr[3:2] : beatCount;
  assign dataWrite = storeHit | ((state == memReadState) & beat);
  assign dataMask = (state == memReadState) ? 4'hf : cpuReq.byteMask;
  assign useBusData = (state == memReadState);

  assign tagWrite = (state == memReadState) & burstDone;
  assign setDirty = storeHit;
  assign cleanLine = (state == writebackState) & burstDone;
  assign touchLru = (state == readyState) & active & hit;

  assert property (@(posedge clk) disable iff (reset)
    state == readyState |-> !busReq.request);

  assert property (@(posedge clk) disable iff (reset)
    !(setDirty && beat));

  // The refilled line must hit as soon as we are back in ready
  assert property (@(posedge clk) disable iff (reset)
    (state == memReadState && burstDone) |=> hit);

endmodule

//--- hw/cachePkg.sv
package cachePkg;

  // Data and address widths seen by the processor and the bus
  typedef logic [31:0] wordT;
  typedef logic [31:0] addrT;

  // One enable per byte lane
  typedef logic [3:0] byteMaskT;

  // Word position inside a block
  typedef logic [1:0] wordOffsetT;

  // Block length in words, also the beats per burst
  localparam int wordsPerBlock = 4;

  // Byte and word-offset bits below the set index
  localparam int blockOffsetBits = 4;

  // Load/store request from the processor
  typedef struct packed {
    logic     read;
    logic     write;
    addrT     addr;
    wordT     wdata;
    byteMaskT byteMask;
  } cpuReqT;

  // One bus beat, held until busReady
  typedef struct packed {
    logic request;
    logic write;
    addrT addr;
    wordT wdata;
  } busReqT;

endpackage
